// File: logic/fetchPkg.sv
package fetchPkg;

  // pc is a byte address
  localparam int pcWidth = 32;

  localparam int instWidth = 32; // one instruction slot

  localparam int fetchWidth = 4; // slots per bundle

  // one cache line is exactly one fetch bundle
  localparam int blockWidth = fetchWidth * instWidth;

  // control-instruction type as stored in the BTB and sent on updates
  typedef enum logic [1:0] {
    CtrlReturn = 2'b00, // target comes from the return stack
    CtrlCall   = 2'b01, // pushes the return address
    CtrlJump   = 2'b10, // always taken
    CtrlBranch = 2'b11  // direction from the counter table
  } ctrlType_e;

endpackage

// File: logic/branchTargetBuffer.sv
`timescale 1ns/10ps

module branchTargetBuffer #(
  parameter int btbEntries = 16
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [fetchPkg::pcWidth-1:0]              pc_i,
  input  logic                                      updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]              updatePC_i,
  input  fetchPkg::ctrlType_e                       updateBrType_i,
  input  logic [fetchPkg::pcWidth-1:0]              updateTargetAddr_i,
  output logic [fetchPkg::fetchWidth-1:0]           btbHit_o,
  output fetchPkg::ctrlType_e [fetchPkg::fetchWidth-1:0] ctrlType_o,
  output logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] targetAddr_o
);

  localparam int slotLsb    = $clog2(fetchPkg::instWidth / 8); // byte offset in a slot
  localparam int offsetBits = $clog2(fetchPkg::blockWidth / 8); // byte offset in a line
  localparam int idxBits    = $clog2(btbEntries);
  localparam int tagBits    = fetchPkg::pcWidth - offsetBits - idxBits;
  localparam int bankBits   = offsetBits - slotLsb;

  // one valid/tag/type/target set per slot bank
  logic [btbEntries-1:0]             valid [fetchPkg::fetchWidth];
  logic [tagBits-1:0]                tagMem [fetchPkg::fetchWidth][btbEntries];
  fetchPkg::ctrlType_e               typeMem [fetchPkg::fetchWidth][btbEntries];
  logic [fetchPkg::pcWidth-1:0]      targetMem [fetchPkg::fetchWidth][btbEntries];

  logic [idxBits-1:0]  rdIdx;
  logic [tagBits-1:0]  rdTag;
  logic [idxBits-1:0]  updIdx;
  logic [tagBits-1:0]  updTag;
  logic [bankBits-1:0] updBank;

  assign rdIdx   = pc_i[offsetBits +: idxBits]; // line address above the offset
  assign rdTag   = pc_i[fetchPkg::pcWidth-1 -: tagBits];
  assign updIdx  = updatePC_i[offsetBits +: idxBits];
  assign updTag  = updatePC_i[fetchPkg::pcWidth-1 -: tagBits];
  assign updBank = updatePC_i[offsetBits-1:slotLsb]; // slot within the line

  // all banks share the same index and tag for the current line
  always_comb begin
    for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
      btbHit_o[b]     = valid[b][rdIdx] && (tagMem[b][rdIdx] == rdTag);
      ctrlType_o[b]   = typeMem[b][rdIdx];
      targetAddr_o[b] = targetMem[b][rdIdx];
    end
  end

  // valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
        valid[b] <= '0;
      end
    end else if (updateEn_i) begin
      valid[updBank][updIdx] <= 1'b1; // entry allocated on any update
    end
  end

  // entry payload, written only in the addressed bank
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagMem[updBank][updIdx]    <= updTag;
      typeMem[updBank][updIdx]   <= updateBrType_i;
      targetMem[updBank][updIdx] <= updateTargetAddr_i; // overwrites older target
    end
  end

endmodule

// File: logic/branchPredictor.sv
`timescale 1ns/10ps

module branchPredictor #(
  parameter int bpEntries = 64
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::pcWidth-1:0]    pc_i,
  input  logic                            updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]    updatePC_i,
  input  logic                            updateDir_i,
  output logic [fetchPkg::fetchWidth-1:0] prediction_o
);

  localparam int slotLsb    = $clog2(fetchPkg::instWidth / 8);
  localparam int offsetBits = $clog2(fetchPkg::blockWidth / 8);
  localparam int idxBits    = $clog2(bpEntries);
  localparam int bankBits   = offsetBits - slotLsb;

  logic [1:0] counter [fetchPkg::fetchWidth][bpEntries]; // 2-bit saturating

  logic [idxBits-1:0]  rdIdx;
  logic [idxBits-1:0]  updIdx;
  logic [bankBits-1:0] updBank;
  logic [1:0]          oldCount;

  assign rdIdx    = pc_i[offsetBits +: idxBits]; // same indexing as BTB, no tag
  assign updIdx   = updatePC_i[offsetBits +: idxBits];
  assign updBank  = updatePC_i[offsetBits-1:slotLsb];
  assign oldCount = counter[updBank][updIdx];

  always_comb begin
    for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
      prediction_o[b] = counter[b][rdIdx][1]; // msb set means taken
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
        for (int e = 0; e < bpEntries; e++) begin
          counter[b][e] <= 2'b01; // weakly not-taken
        end
      end
    end else if (updateEn_i) begin
      if (updateDir_i && oldCount != 2'b11) begin
        counter[updBank][updIdx] <= oldCount + 2'b01; // count up toward strong taken
      end else if (!updateDir_i && oldCount != 2'b00) begin
        counter[updBank][updIdx] <= oldCount - 2'b01;
      end
    end
  end

endmodule

// File: logic/returnAddressStack.sv
`timescale 1ns/10ps

module returnAddressStack #(
  parameter int rasDepth = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push_i,
  input  logic [fetchPkg::pcWidth-1:0] pushAddr_i,
  input  logic                         pop_i,
  output logic [fetchPkg::pcWidth-1:0] addrRas_o
);

  localparam int ptrBits = (rasDepth > 1) ? $clog2(rasDepth) : 1;

  logic [fetchPkg::pcWidth-1:0] stack [rasDepth];
  logic [ptrBits-1:0]           topPtr;  // points at the current top entry
  logic [ptrBits-1:0]           nextPtr;
  logic [ptrBits-1:0]           prevPtr;

  // circular increment and decrement, any depth
  assign nextPtr = (topPtr == ptrBits'(rasDepth - 1)) ? '0 : topPtr + 1'b1;
  assign prevPtr = (topPtr == '0) ? ptrBits'(rasDepth - 1) : topPtr - 1'b1;

  assign addrRas_o = stack[topPtr]; // 0 when empty after reset

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      for (int i = 0; i < rasDepth; i++) begin
        stack[i] <= '0;
      end
    end else if (push_i) begin
      topPtr         <= nextPtr;
      stack[nextPtr] <= pushAddr_i; // overflow drops the oldest entry
    end else if (pop_i) begin
      topPtr <= prevPtr; // entry stays, only pointer moves
    end
  end

endmodule

// File: logic/instCache.sv
`timescale 1ns/10ps

module instCache #(
  parameter int cacheLines = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::pcWidth-1:0]    addr_i,
  input  logic                            wrEnable_i,
  input  logic [fetchPkg::pcWidth-1:0]    wrAddr_i,
  input  logic [fetchPkg::blockWidth-1:0] instBlock_i,
  output logic [fetchPkg::blockWidth-1:0] instBundle_o,
  output logic                            miss_o,
  output logic [fetchPkg::pcWidth-1:0]    missAddr_o
);

  localparam int offsetBits = $clog2(fetchPkg::blockWidth / 8);
  localparam int idxBits    = $clog2(cacheLines);
  localparam int tagBits    = fetchPkg::pcWidth - offsetBits - idxBits;

  logic [fetchPkg::blockWidth-1:0] dataMem [cacheLines];
  logic [tagBits-1:0]              tagMem [cacheLines];
  logic [cacheLines-1:0]           valid;

  logic [idxBits-1:0] rdIdx;
  logic [tagBits-1:0] rdTag;
  logic [idxBits-1:0] wrIdx;
  logic [tagBits-1:0] wrTag;

  assign rdIdx = addr_i[offsetBits +: idxBits];
  assign rdTag = addr_i[fetchPkg::pcWidth-1 -: tagBits];
  assign wrIdx = wrAddr_i[offsetBits +: idxBits];
  assign wrTag = wrAddr_i[fetchPkg::pcWidth-1 -: tagBits];

  // whole line out, read is combinational
  assign instBundle_o = dataMem[rdIdx];
  assign miss_o       = !(valid[rdIdx] && (tagMem[rdIdx] == rdTag)); // invalid or mismatch
  assign missAddr_o   = {addr_i[fetchPkg::pcWidth-1:offsetBits], offsetBits'(0)}; // line aligned

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (wrEnable_i) begin
      valid[wrIdx] <= 1'b1;
    end
  end

  // refill data and tag, visible from the next cycle
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      dataMem[wrIdx] <= instBlock_i;
      tagMem[wrIdx]  <= wrTag;
    end
  end

endmodule

// File: logic/fetchStage1.sv
`timescale 1ns/10ps

module fetchStage1 #(
  parameter int btbEntries = 16,
  parameter int bpEntries  = 64,
  parameter int rasDepth   = 8,
  parameter int cacheLines = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            stall_i,
  input  logic                            recoverFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]    recoverPC_i,
  input  logic                            exceptionFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]    exceptionPC_i,
  input  logic                            flagRecoverID_i,
  input  logic [fetchPkg::pcWidth-1:0]    targetAddrID_i,
  input  logic                            flagRecoverEX_i,
  input  logic [fetchPkg::pcWidth-1:0]    targetAddrEX_i,
  input  logic                            updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]    updatePC_i,
  input  logic [fetchPkg::pcWidth-1:0]    updateTargetAddr_i,
  input  fetchPkg::ctrlType_e             updateBrType_i,
  input  logic                            updateDir_i,
  input  logic                            wrEnable_i,
  input  logic [fetchPkg::pcWidth-1:0]    wrAddr_i,
  input  logic [fetchPkg::blockWidth-1:0] instBlock_i,
  output logic                            fs1Ready_o,
  output logic [fetchPkg::blockWidth-1:0] instructionBundle_o,
  output logic [fetchPkg::pcWidth-1:0]    pc_o,
  output logic [fetchPkg::fetchWidth-1:0] btbHit_o,
  output logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] targetAddr_o,
  output logic [fetchPkg::fetchWidth-1:0] prediction_o,
  output logic                            miss_o,
  output logic [fetchPkg::pcWidth-1:0]    missAddr_o
);

  localparam int slotLsb    = $clog2(fetchPkg::instWidth / 8);
  localparam int offsetBits = $clog2(fetchPkg::blockWidth / 8);
  localparam int slotBits   = offsetBits - slotLsb;

  logic [fetchPkg::pcWidth-1:0]    pc;
  logic [fetchPkg::pcWidth-1:0]    linePC;     // pc with offset cleared
  logic [slotBits-1:0]             wordOffset; // first slot to consider
  logic [fetchPkg::fetchWidth-1:0] btbHit;
  logic [fetchPkg::fetchWidth-1:0] prediction;
  logic [fetchPkg::fetchWidth-1:0] slotTaken;
  fetchPkg::ctrlType_e [fetchPkg::fetchWidth-1:0] ctrlType;
  logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] btbTarget;
  logic [fetchPkg::pcWidth-1:0]    rasTop;
  logic [fetchPkg::pcWidth-1:0]    predPC;
  logic [fetchPkg::pcWidth-1:0]    pushAddr;
  logic [slotBits-1:0]             firstSlot;
  logic                            anyTaken;
  logic                            predAdvance;
  logic                            pushRas;
  logic                            popRas;
  logic                            miss;
  logic                            updateBtb;
  logic                            updateBp;

  // untaken branches never allocate a BTB entry
  assign updateBtb = updateEn_i &&
                     !(updateBrType_i == fetchPkg::CtrlBranch && !updateDir_i);
  assign updateBp  = updateEn_i && (updateBrType_i == fetchPkg::CtrlBranch);

  branchTargetBuffer #(.btbEntries(btbEntries)) btb_i (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updateBtb), .updatePC_i(updatePC_i),
    .updateBrType_i(updateBrType_i), .updateTargetAddr_i(updateTargetAddr_i),
    .btbHit_o(btbHit), .ctrlType_o(ctrlType), .targetAddr_o(btbTarget)
  );

  branchPredictor #(.bpEntries(bpEntries)) bp_i (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updateBp), .updatePC_i(updatePC_i), .updateDir_i(updateDir_i),
    .prediction_o(prediction)
  );

  returnAddressStack #(.rasDepth(rasDepth)) ras_i (
    .clk(clk), .reset(reset), .push_i(pushRas), .pushAddr_i(pushAddr),
    .pop_i(popRas), .addrRas_o(rasTop)
  );

  instCache #(.cacheLines(cacheLines)) icache_i (
    .clk(clk), .reset(reset), .addr_i(pc),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .instBundle_o(instructionBundle_o), .miss_o(miss), .missAddr_o(missAddr_o)
  );

  assign linePC     = {pc[fetchPkg::pcWidth-1:offsetBits], offsetBits'(0)};
  assign wordOffset = pc[offsetBits-1:slotLsb];

  // slot taken: at/after offset, BTB hit, and not a not-taken branch
  always_comb begin
    for (int s = 0; s < fetchPkg::fetchWidth; s++) begin
      slotTaken[s] = (s >= int'(wordOffset)) && btbHit[s] &&
                     (ctrlType[s] != fetchPkg::CtrlBranch || prediction[s]);
    end
  end

  // priority encode, lowest taken slot wins
  always_comb begin
    anyTaken  = 1'b0;
    firstSlot = '0;
    for (int s = fetchPkg::fetchWidth - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        anyTaken  = 1'b1;
        firstSlot = slotBits'(s);
      end
    end
  end

  always_comb begin
    if (!anyTaken) begin
      predPC = linePC + fetchPkg::pcWidth'(fetchPkg::blockWidth / 8); // next bundle
    end else if (ctrlType[firstSlot] == fetchPkg::CtrlReturn) begin
      predPC = rasTop;
    end else begin
      predPC = btbTarget[firstSlot];
    end
  end

  // ras only moves when the pc advances by prediction
  assign predAdvance = !stall_i && !miss && !recoverFlag_i && !exceptionFlag_i &&
                       !flagRecoverEX_i && !flagRecoverID_i;
  assign pushRas  = predAdvance && anyTaken && (ctrlType[firstSlot] == fetchPkg::CtrlCall);
  assign popRas   = predAdvance && anyTaken && (ctrlType[firstSlot] == fetchPkg::CtrlReturn);
  assign pushAddr = (linePC | (fetchPkg::pcWidth'(firstSlot) << slotLsb)) +
                    fetchPkg::pcWidth'(fetchPkg::instWidth / 8); // return point after call

  // recoveries act even under stall or miss
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (recoverFlag_i) begin
      pc <= recoverPC_i; // commit-time, highest
    end else if (exceptionFlag_i) begin
      pc <= exceptionPC_i;
    end else if (flagRecoverEX_i) begin
      pc <= targetAddrEX_i;
    end else if (flagRecoverID_i) begin
      pc <= targetAddrID_i;
    end else if (predAdvance) begin
      pc <= predPC;
    end
  end

  always_comb begin
    for (int s = 0; s < fetchPkg::fetchWidth; s++) begin
      targetAddr_o[s] = (ctrlType[s] == fetchPkg::CtrlReturn) ? rasTop : btbTarget[s];
    end
  end

  assign pc_o         = pc;
  assign btbHit_o     = btbHit;
  assign prediction_o = prediction;
  assign miss_o       = miss;
  assign fs1Ready_o   = !miss; // bundle valid this cycle

endmodule

// File: verif/fetchTests.svh
`ifndef FETCH_TESTS_SVH
`define FETCH_TESTS_SVH

task automatic expectPC(input logic [31:0] expPC);
  @(negedge clk); // outputs settled mid-cycle
  assert (pc == expPC)
    else reportFailure($sformatf("pc is %h, expected %h", pc, expPC));
endtask

task automatic checkBundle();
  logic [fetchPkg::blockWidth-1:0] expLine;
  expLine = lineData[pc[lineBits +: cacheIdxBits]];
  assert (fs1Ready && !miss)
    else reportFailure($sformatf("fetch at %h not ready", pc));
  assert (instructionBundle == expLine)
    else reportFailure($sformatf("bundle at %h is %h, expected %h", pc, instructionBundle, expLine));
endtask

function automatic logic [fetchPkg::fetchWidth-1:0] modelPrediction(input logic [31:0] addr);
  logic [fetchPkg::fetchWidth-1:0] p;
  for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
    p[b] = bpModel[b][addr[lineBits +: bpIdxBits]][1]; // msb of each bank
  end
  return p;
endfunction

task automatic checkSlots(input logic [fetchPkg::fetchWidth-1:0] expHit);
  assert (btbHit == expHit)
    else reportFailure($sformatf("btbHit at %h is %b, expected %b", pc, btbHit, expHit));
  assert (prediction == modelPrediction(pc))
    else reportFailure($sformatf("prediction at %h is %b, expected %b", pc, prediction,
                                 modelPrediction(pc)));
endtask

task automatic refillLine(input logic [31:0] lineAddr);
  logic [fetchPkg::blockWidth-1:0] data;
  for (int w = 0; w < fetchPkg::fetchWidth; w++) begin
    rngState = xorshift(rngState);
    data[w*fetchPkg::instWidth +: fetchPkg::instWidth] = rngState;
  end
  lineData[lineAddr[lineBits +: cacheIdxBits]] = data;
  @(posedge clk);
  wrEnable <= 1'b1;
  wrAddr <= lineAddr;
  instBlock <= data;
  @(posedge clk); // line written here
  wrEnable <= 1'b0;
endtask

task automatic sendUpdate(input logic [31:0] addr, input logic [31:0] target,
                          input fetchPkg::ctrlType_e kind, input logic taken);
  logic [1:0] cnt;
  if (kind == fetchPkg::CtrlBranch) begin
    cnt = bpModel[addr[lineBits-1:2]][addr[lineBits +: bpIdxBits]];
    if (taken && cnt != 2'b11) begin
      cnt = cnt + 2'b01;
    end else if (!taken && cnt != 2'b00) begin
      cnt = cnt - 2'b01;
    end
    bpModel[addr[lineBits-1:2]][addr[lineBits +: bpIdxBits]] = cnt;
  end
  @(posedge clk);
  updateEn <= 1'b1;
  updatePC <= addr;
  updateTargetAddr <= target;
  updateBrType <= kind;
  updateDir <= taken;
  @(posedge clk);
  updateEn <= 1'b0;
endtask

task automatic forcePC(input logic [31:0] addr);
  @(posedge clk);
  recoverFlag <= 1'b1;
  recoverPC <= addr;
  @(posedge clk); // pc loads addr
  recoverFlag <= 1'b0;
endtask

task automatic predictOnce();
  @(posedge clk);
  stall <= 1'b0;
  @(posedge clk); // one predicted step
  stall <= 1'b1;
endtask

task automatic coldMissRefill();
  @(negedge clk);
  assert (miss && !fs1Ready && missAddr == 32'h0)
    else reportFailure($sformatf("after reset miss=%b ready=%b missAddr=%h",
                                 miss, fs1Ready, missAddr));
  repeat (3) expectPC(32'h0); // held by the miss
  @(posedge clk);
  stall <= 1'b1;
  refillLine(32'h0);
  expectPC(32'h0);
  checkBundle();
  for (int a = 16; a < 64; a += 16) begin
    refillLine(a);
  end
  @(posedge clk);
  stall <= 1'b0;
  for (int a = 0; a < 64; a += 16) begin
    expectPC(a); // no BTB entries yet
    checkBundle();
  end
  expectPC(32'h40);
  assert (miss && missAddr == 32'h40)
    else reportFailure($sformatf("at 40 miss=%b missAddr=%h", miss, missAddr));
  @(posedge clk);
  stall <= 1'b1;
endtask

task automatic jumpRedirect();
  refillLine(32'h40);
  sendUpdate(32'h24, 32'h44, fetchPkg::CtrlJump, 1'b1);
  forcePC(32'h20);
  expectPC(32'h20);
  checkSlots(4'b0010);
  assert (targetAddr[1] == 32'h44)
    else reportFailure($sformatf("slot 1 target is %h, expected 44", targetAddr[1]));
  predictOnce();
  expectPC(32'h44);
  forcePC(32'h28); // offset 2 skips the jump
  expectPC(32'h28);
  checkSlots(4'b0010);
  predictOnce();
  expectPC(32'h30);
endtask

task automatic branchDirection();
  refillLine(32'h50);
  forcePC(32'h50);
  expectPC(32'h50);
  checkSlots(4'b0000);
  sendUpdate(32'h58, 32'h10, fetchPkg::CtrlBranch, 1'b1); // counter to weakly taken
  expectPC(32'h50);
  checkSlots(4'b0100);
  predictOnce();
  expectPC(32'h10);
  sendUpdate(32'h58, 32'h70, fetchPkg::CtrlBranch, 1'b0); // back to weakly not-taken
  forcePC(32'h50);
  expectPC(32'h50);
  checkSlots(4'b0100); // entry stays while direction flips
  assert (targetAddr[2] == 32'h10) // untaken update wrote no entry
    else reportFailure($sformatf("slot 2 target is %h, expected 10", targetAddr[2]));
  predictOnce();
  expectPC(32'h60);
endtask

task automatic callReturn();
  refillLine(32'h80);
  sendUpdate(32'h48, 32'h80, fetchPkg::CtrlCall, 1'b1);
  sendUpdate(32'h80, 32'h0, fetchPkg::CtrlReturn, 1'b1);
  forcePC(32'h40);
  expectPC(32'h40);
  checkSlots(4'b0100);
  predictOnce(); // call pushes 4c
  expectPC(32'h80);
  checkSlots(4'b0001);
  assert (targetAddr[0] == 32'h4c)
    else reportFailure($sformatf("return target is %h, expected 4c", targetAddr[0]));
  predictOnce();
  expectPC(32'h4c);
endtask

task automatic recoveryPriority();
  logic [31:0] targets [4];
  logic [3:0] flags;
  targets = '{32'h100, 32'h200, 32'h300, 32'h400};
  forcePC(32'h20);
  repeat (3) expectPC(32'h20); // stall holds a hitting pc
  @(posedge clk);
  recoverPC <= targets[0];
  exceptionPC <= targets[1];
  targetAddrEX <= targets[2];
  targetAddrID <= targets[3];
  for (int pass = 0; pass < 2; pass++) begin
    for (int level = 0; level < 4; level++) begin
      flags = 4'b1111 >> level; // drop highest flag each step
      @(posedge clk);
      stall <= (pass == 0);
      recoverFlag <= flags[3];
      exceptionFlag <= flags[2];
      flagRecoverEX <= flags[1];
      flagRecoverID <= flags[0];
      @(posedge clk);
      expectPC(targets[level]);
    end
    @(posedge clk);
    recoverFlag <= 1'b0;
    exceptionFlag <= 1'b0;
    flagRecoverEX <= 1'b0;
    flagRecoverID <= 1'b0;
    @(posedge clk); // first edge with all flags low
    expectPC(32'h400); // held by stall or by the miss on an unfilled line
  end
endtask

`endif

// File: verif/fetchTb.sv
`timescale 1ns/10ps

module fetchTb;

  localparam int cycleLimit   = 3000; // far above what the tests use
  localparam int cacheLines   = 32;   // dut defaults
  localparam int bpEntries    = 64;
  localparam int lineBytes    = fetchPkg::blockWidth / 8;
  localparam int lineBits     = $clog2(lineBytes);
  localparam int cacheIdxBits = $clog2(cacheLines);
  localparam int bpIdxBits    = $clog2(bpEntries);

  logic clk;
  logic reset;
  logic stall;
  logic recoverFlag;
  logic exceptionFlag;
  logic flagRecoverID;
  logic flagRecoverEX;
  logic [fetchPkg::pcWidth-1:0] recoverPC;
  logic [fetchPkg::pcWidth-1:0] exceptionPC;
  logic [fetchPkg::pcWidth-1:0] targetAddrID;
  logic [fetchPkg::pcWidth-1:0] targetAddrEX;
  logic updateEn;
  logic updateDir;
  logic [fetchPkg::pcWidth-1:0] updatePC;
  logic [fetchPkg::pcWidth-1:0] updateTargetAddr;
  fetchPkg::ctrlType_e updateBrType;
  logic wrEnable;
  logic [fetchPkg::pcWidth-1:0] wrAddr;
  logic [fetchPkg::blockWidth-1:0] instBlock;

  logic fs1Ready;
  logic [fetchPkg::blockWidth-1:0] instructionBundle;
  logic [fetchPkg::pcWidth-1:0] pc;
  logic [fetchPkg::fetchWidth-1:0] btbHit;
  logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] targetAddr;
  logic [fetchPkg::fetchWidth-1:0] prediction;
  logic miss;
  logic [fetchPkg::pcWidth-1:0] missAddr;

  logic [fetchPkg::blockWidth-1:0] lineData [cacheLines]; // what each refill wrote
  logic [1:0] bpModel [fetchPkg::fetchWidth][bpEntries];  // expected direction counters
  logic [31:0] rngState;
  int cycleCount = 0;

  fetchStage1 dut_i (
    .clk(clk), .reset(reset), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .recoverPC_i(recoverPC),
    .exceptionFlag_i(exceptionFlag), .exceptionPC_i(exceptionPC),
    .flagRecoverID_i(flagRecoverID), .targetAddrID_i(targetAddrID),
    .flagRecoverEX_i(flagRecoverEX), .targetAddrEX_i(targetAddrEX),
    .updateEn_i(updateEn), .updatePC_i(updatePC), .updateTargetAddr_i(updateTargetAddr),
    .updateBrType_i(updateBrType), .updateDir_i(updateDir),
    .wrEnable_i(wrEnable), .wrAddr_i(wrAddr), .instBlock_i(instBlock),
    .fs1Ready_o(fs1Ready), .instructionBundle_o(instructionBundle), .pc_o(pc),
    .btbHit_o(btbHit), .targetAddr_o(targetAddr), .prediction_o(prediction),
    .miss_o(miss), .missAddr_o(missAddr)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk; // 40 ns period

  always @(posedge clk) cycleCount <= cycleCount + 1;

  initial begin : watchdog
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
    end
    $display("timeout: run did not finish within %0d cycles", cycleLimit);
    $display("tests failed");
    $fatal(1);
  end

  task automatic reportFailure(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  `include "fetchTests.svh"

  initial begin
    rngState = 32'hc4ea_e878;
    reset = 1'b1;
    stall = 1'b0;
    recoverFlag = 1'b0;
    exceptionFlag = 1'b0;
    flagRecoverID = 1'b0;
    flagRecoverEX = 1'b0;
    recoverPC = '0;
    exceptionPC = '0;
    targetAddrID = '0;
    targetAddrEX = '0;
    updateEn = 1'b0;
    updateDir = 1'b0;
    updatePC = '0;
    updateTargetAddr = '0;
    updateBrType = fetchPkg::CtrlJump;
    wrEnable = 1'b0;
    wrAddr = '0;
    instBlock = '0;
    for (int b = 0; b < fetchPkg::fetchWidth; b++) begin
      for (int e = 0; e < bpEntries; e++) begin
        bpModel[b][e] = 2'b01; // weakly not-taken after reset
      end
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    coldMissRefill();
    jumpRedirect();
    branchDirection();
    callReturn();
    recoveryPriority();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+verif
logic/fetchPkg.sv
logic/branchTargetBuffer.sv
logic/branchPredictor.sv
logic/returnAddressStack.sv
logic/instCache.sv
logic/fetchStage1.sv
verif/fetchTb.sv

// File: run.sh
#!/bin/sh
# build the fetch stage with its testbench and run it under verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module fetchTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VfetchTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
fi

if echo "$simOut" | grep -qx "all tests passed"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
